// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= fc_layer_tb
RTL_TOP   ?= fc_layer
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
RUNFLAGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
common/fc_types_pkg.sv
common/fc_geom_pkg.sv
fc_front/fc_front.sv
src/fc_addr_gen.sv
src/fc_argmax.sv
src/fc_layer.sv
bench/fc_layer_assert.sv
bench/fc_layer_check.sv
bench/fc_layer_tb.sv

// File: bench/fc_layer_assert.sv
// Watches the argmax and sequencer outputs at the layer ports; bases assumed stable while busy
`timescale 1ns/100ps

module fc_layer_assert (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_result_valid,
    input  logic                      i_result_ready,
    input  logic                      i_busy,
    input  fc_types_pkg::fc_class_t   i_class,
    input  fc_types_pkg::fc_acc_t     i_score,
    input  fc_types_pkg::fc_fm_base_t i_fm_base,
    input  fc_types_pkg::fc_wt_base_t i_wt_base,
    input  fc_types_pkg::fc_fm_addr_t i_fm_addr,
    input  fc_types_pkg::fc_wt_addr_t i_wt_addr
);
    import fc_geom_pkg::*;

    int assert_fails = 0;

    held_result: assert property (@(posedge clk) disable iff (!rst_n)
        i_result_valid && !i_result_ready
        |=> i_result_valid && $stable(i_class) && $stable(i_score))
        else begin
            $error("Result changed or dropped while held without ready");
            assert_fails++;
        end

    valid_busy: assert property (@(posedge clk) disable iff (!rst_n)
        i_result_valid |-> i_busy)
        else begin
            $error("Result valid while the layer is not busy");
            assert_fails++;
        end

    // Feature reads stay in one row, weight reads in all rows
    addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        (int'(i_fm_addr) >= int'(i_fm_base))
        && (int'(i_fm_addr) < int'(i_fm_base) + WORDS_PER_ROW)
        && (int'(i_wt_addr) >= int'(i_wt_base))
        && (int'(i_wt_addr) < int'(i_wt_base) + TOTAL_READS))
        else begin
            $error("Memory address outside the base window");
            assert_fails++;
        end

endmodule

bind fc_layer fc_layer_assert u_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_result_valid (o_result_valid),
    .i_result_ready (i_result_ready),
    .i_busy         (o_busy),
    .i_class        (o_class),
    .i_score        (o_score),
    .i_fm_base      (i_fm_base),
    .i_wt_base      (i_wt_base),
    .i_fm_addr      (o_fm_addr),
    .i_wt_addr      (o_wt_addr)
);

// File: bench/fc_layer_check.sv
// Model reads the testbench memories, which must not change while a run is in flight
`timescale 1ns/100ps

module fc_layer_check (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_start,
    input  logic                      i_busy,
    input  fc_types_pkg::fc_fm_base_t i_fm_base,
    input  fc_types_pkg::fc_wt_base_t i_wt_base,
    input  logic                      i_result_valid,
    input  logic                      i_result_ready,
    input  fc_types_pkg::fc_class_t   i_class,
    input  fc_types_pkg::fc_acc_t     i_score,
    input  int                        i_exp_class
);
    import fc_types_pkg::*;
    import fc_geom_pkg::*;

    int   err_cnt     = 0;
    int   test_cnt    = 0;
    int   cycle       = 0;
    int   start_cycle = 0;
    int   rise_cycle  = 0;
    int   fm_b        = 0;
    int   wt_b        = 0;
    logic pending     = 1'b0;
    logic valid_q     = 1'b0;
    logic busy_q      = 1'b0;
    logic accept_q    = 1'b0;
    logic taken_q     = 1'b0;

    function automatic int row_score(input int c);
        fc_word_t fm_w;
        fc_word_t wt_w;
        int       sum;
        sum = 0;
        for (int w = 0; w < WORDS_PER_ROW; w++) begin
            fm_w = fc_layer_tb.fm_mem[fm_b + w];
            wt_w = fc_layer_tb.wt_mem[wt_b + c * WORDS_PER_ROW + w];
            for (int l = 0; l < LANES; l++) begin
                sum += int'($signed(fm_w[l*DATA_W +: DATA_W]))
                     * int'($signed(wt_w[l*DATA_W +: DATA_W]));
            end
        end
        return sum;
    endfunction

    task automatic report_mismatch(input string sig, input int exp, input int got);
        $display("[FAIL] t=%0t %s expected %0d got %0d", $time, sig, exp, got);
        err_cnt++;
    endtask

    task automatic check_result();
        int best;
        int best_c;
        int s;
        int errs_before;
        int latency;
        best        = 0;
        best_c      = 0;
        errs_before = err_cnt;
        if (!pending) begin
            $display("Result handshake at t=%0t with no accepted start", $time);
            err_cnt++;
            return;
        end
        for (int c = 0; c < NUM_CLASSES; c++) begin
            s = row_score(c);
            // Class 0 seeds the search and later rows must be strictly greater
            if (c == 0 || s > best) begin
                best   = s;
                best_c = c;
            end
        end
        latency = rise_cycle - start_cycle;
        if (int'(i_class) != best_c) begin
            report_mismatch("o_class", best_c, int'(i_class));
        end
        if (int'(i_score) != best) begin
            report_mismatch("o_score", best, int'(i_score));
        end
        if (i_exp_class >= 0 && int'(i_class) != i_exp_class) begin
            report_mismatch("o_class", i_exp_class, int'(i_class));
        end
        if (latency != TOTAL_READS + FRONT_DEPTH) begin
            report_mismatch("o_result_valid latency", TOTAL_READS + FRONT_DEPTH, latency);
        end
        if (err_cnt == errs_before) begin
            $display("[PASS] test %0d class %0d score %0d latency %0d",
                     test_cnt, best_c, best, latency);
        end else begin
            $display("test %0d finished with %0d mismatches", test_cnt, err_cnt - errs_before);
        end
        test_cnt++;
        pending = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle++;
        if (rst_n) begin
            // A run begins only on a start seen while idle
            if (i_busy && !busy_q && !accept_q) begin
                report_mismatch("o_busy", 0, 1);
            end
            // Cycle after a transfer the layer is idle again
            if (taken_q && i_result_valid) begin
                report_mismatch("o_result_valid", 0, 1);
            end
            if (taken_q && i_busy) begin
                report_mismatch("o_busy", 0, 1);
            end
            if (i_start && !i_busy) begin
                pending     = 1'b1;
                start_cycle = cycle;
                fm_b        = int'(i_fm_base);
                wt_b        = int'(i_wt_base);
            end
            // Valid first seen high here was set by the edge before
            if (i_result_valid && !valid_q) begin
                rise_cycle = cycle - 1;
                if (!pending) begin
                    $display("o_result_valid rose at t=%0t with no accepted start", $time);
                    err_cnt++;
                end
            end
            if (i_result_valid && i_result_ready) begin
                check_result();
            end
            taken_q  = i_result_valid && i_result_ready;
            accept_q = i_start && !i_busy;
            busy_q   = i_busy;
            valid_q  = i_result_valid;
        end
    end

endmodule

// File: bench/fc_layer_tb.sv
// Memory sizes follow the base widths; table bases must keep every read inside the memories
`timescale 1ns/100ps

module fc_layer_tb;
    import fc_types_pkg::*;
    import fc_geom_pkg::*;

    localparam int FM_DEPTH  = 2 ** FM_BASE_W;
    localparam int WT_DEPTH  = 2 ** WT_BASE_W;
    localparam int NUM_TESTS = 6;

    typedef enum int {
        FILL_RANDOM,
        FILL_TIE,
        FILL_NEG
    } fill_t;

    // Winner below zero means no forced row, exp_class below zero means model only
    typedef struct {
        fill_t mode;
        int    fm_base;
        int    wt_base;
        int    winner;
        int    ready_delay;
        bit    extra_start;
        int    exp_class;
    } test_t;

    test_t       tests [NUM_TESTS];
    fc_word_t    fm_mem [FM_DEPTH];
    fc_word_t    wt_mem [WT_DEPTH];
    fc_word_t    fm_rdata = '0;
    fc_word_t    wt_rdata = '0;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        result_ready;
    fc_fm_base_t fm_base;
    fc_wt_base_t wt_base;
    fc_fm_addr_t fm_addr;
    fc_wt_addr_t wt_addr;
    logic        result_valid;
    fc_class_t   res_class;
    fc_acc_t     res_score;
    logic        busy;
    int          exp_class;
    int          errors;

    fc_layer dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_start        (start),
        .i_fm_base      (fm_base),
        .i_wt_base      (wt_base),
        .i_fm_data      (fm_rdata),
        .i_wt_data      (wt_rdata),
        .o_fm_addr      (fm_addr),
        .o_wt_addr      (wt_addr),
        .o_result_valid (result_valid),
        .i_result_ready (result_ready),
        .o_class        (res_class),
        .o_score        (res_score),
        .o_busy         (busy)
    );

    fc_layer_check u_check (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_start        (start),
        .i_busy         (busy),
        .i_fm_base      (fm_base),
        .i_wt_base      (wt_base),
        .i_result_valid (result_valid),
        .i_result_ready (result_ready),
        .i_class        (res_class),
        .i_score        (res_score),
        .i_exp_class    (exp_class)
    );

    // Synchronous memories, one cycle of read latency
    always @(posedge clk) begin
        fm_rdata <= fm_mem[fm_addr[FM_BASE_W-1:0]];
        wt_rdata <= wt_mem[wt_addr[WT_BASE_W-1:0]];
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic fc_word_t lane_word(input int lo, input int span);
        fc_word_t w;
        for (int l = 0; l < LANES; l++) begin
            w[l*DATA_W +: DATA_W] = 8'(lo + int'($urandom % span));
        end
        return w;
    endfunction

    function automatic int max_delay();
        int m;
        m = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (tests[i].ready_delay > m) begin
                m = tests[i].ready_delay;
            end
        end
        return m;
    endfunction

    // Weight row equal to the feature map gives the largest score
    task automatic copy_row(input test_t t, input int c);
        for (int w = 0; w < WORDS_PER_ROW; w++) begin
            wt_mem[t.wt_base + c * WORDS_PER_ROW + w] = fm_mem[t.fm_base + w];
        end
    endtask

    task automatic fill_memories(input test_t t);
        int fm_lo;
        int fm_span;
        fm_lo   = -128;
        fm_span = 256;
        // Positive features against negative weights
        if (t.mode == FILL_NEG) begin
            fm_lo   = 1;
            fm_span = 127;
        end
        for (int a = 0; a < FM_DEPTH; a++) begin
            fm_mem[a] = lane_word(fm_lo, fm_span);
        end
        for (int a = 0; a < WT_DEPTH; a++) begin
            wt_mem[a] = (t.mode == FILL_NEG) ? lane_word(-128, 128) : lane_word(-128, 256);
        end
        if (t.winner >= 0) begin
            copy_row(t, t.winner);
        end
        if (t.mode == FILL_TIE) begin
            copy_row(t, NUM_CLASSES - 1);
        end
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic run_test(input test_t t);
        fill_memories(t);
        fm_base   = fc_fm_base_t'(t.fm_base);
        wt_base   = fc_wt_base_t'(t.wt_base);
        exp_class = t.exp_class;
        @(negedge clk);
        pulse_start();
        // Stray start in the middle of the read phase
        if (t.extra_start) begin
            repeat (200) @(negedge clk);
            pulse_start();
        end
        while (!result_valid) begin
            @(negedge clk);
        end
        // Stray start while the result is held
        if (t.extra_start) begin
            pulse_start();
        end
        repeat (t.ready_delay) @(negedge clk);
        result_ready = 1'b1;
        @(negedge clk);
        result_ready = 1'b0;
        while (busy) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h3c81));
        rst_n        = 1'b0;
        start        = 1'b0;
        result_ready = 1'b0;
        fm_base      = '0;
        wt_base      = '0;
        exp_class    = -1;
        tests[0] = '{FILL_RANDOM, 0, 0, -1, 0, 1'b0, -1};
        tests[1] = '{FILL_RANDOM, 0, 0, 17, 0, 1'b0, 17};
        tests[2] = '{FILL_TIE, 0, 0, 5, 2, 1'b0, 5};
        tests[3] = '{FILL_NEG, 0, 0, -1, 0, 1'b0, -1};
        tests[4] = '{FILL_RANDOM, 301, 5000, 11, 0, 1'b0, 11};
        tests[5] = '{FILL_RANDOM, 464, 6800, -1, 25, 1'b1, -1};
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(tests[i]);
        end
        errors = u_check.err_cnt + dut.u_assert.assert_fails;
        if (u_check.test_cnt != NUM_TESTS) begin
            $display("Only %0d of %0d results were checked", u_check.test_cnt, NUM_TESTS);
            errors++;
        end
        $display("tests %0d, checked %0d, assertion failures %0d, errors %0d",
                 NUM_TESTS, u_check.test_cnt, dut.u_assert.assert_fails, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        @(posedge rst_n);
        limit = NUM_TESTS * (TOTAL_READS + FRONT_DEPTH + max_delay() + 20);
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a result never completed", limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: common/fc_geom_pkg.sv
// Geometry is fixed at build time; the layer has no runtime shape configuration
package fc_geom_pkg;

    // Bytes per memory word
    localparam int LANES         = 8;

    // Words in the feature map and in one weight row
    localparam int WORDS_PER_ROW = 48;

    localparam int NUM_CLASSES   = 29;

    // One read per word of every weight row
    localparam int TOTAL_READS   = NUM_CLASSES * WORDS_PER_ROW;

    // Address issue to score valid
    // memory 1, multiply 1, adder tree 2, accumulate 1
    localparam int FRONT_DEPTH   = 5;

    localparam int WORD_IDX_W    = 6;

    typedef logic [WORD_IDX_W-1:0] fc_word_idx_t;

endpackage

// File: common/fc_types_pkg.sv
// Widths assume signed 8-bit lanes and rows of at most 384 products, so scores cannot overflow
package fc_types_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Basic widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int DATA_W    = 8;
    localparam int WORD_W    = 64;
    localparam int PROD_W    = 2 * DATA_W;

    // 384 products of 15-bit magnitude fit in 25 signed bits
    localparam int ACC_W     = 25;
    localparam int CLASS_W   = 5;
    localparam int ADDR_W    = 16;
    localparam int FM_BASE_W = 9;
    localparam int WT_BASE_W = 13;

    ////////////////////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////////////////////

    // Memory word, lane 0 in the low byte
    typedef logic        [WORD_W-1:0]    fc_word_t;

    typedef logic signed [DATA_W-1:0]    fc_byte_t;
    typedef logic signed [PROD_W-1:0]    fc_prod_t;
    typedef logic signed [ACC_W-1:0]     fc_acc_t;

    typedef logic        [CLASS_W-1:0]   fc_class_t;

    // Memory addresses
    typedef logic        [ADDR_W-1:0]    fc_fm_addr_t;
    typedef logic        [ADDR_W-1:0]    fc_wt_addr_t;

    // Base inputs, zero extended into the address
    typedef logic        [FM_BASE_W-1:0] fc_fm_base_t;
    typedef logic        [WT_BASE_W-1:0] fc_wt_base_t;

endpackage

// File: fc_front/fc_front.sv
// Data to score takes 4 cycles; i_last must mark the final word of every row
`timescale 1ns/100ps

module fc_front (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_valid,
    input  logic                    i_last,
    input  fc_types_pkg::fc_class_t i_class,
    input  fc_types_pkg::fc_word_t  i_fm_word,
    input  fc_types_pkg::fc_word_t  i_wt_word,
    output logic                    o_score_valid,
    output fc_types_pkg::fc_acc_t   o_score,
    output fc_types_pkg::fc_class_t o_score_class
);
    import fc_types_pkg::*;
    import fc_geom_pkg::*;

    fc_byte_t  fm_lane [LANES];
    fc_byte_t  wt_lane [LANES];
    fc_prod_t  prod_q  [LANES];
    fc_acc_t   pair_q  [LANES/2];
    fc_acc_t   word_sum;
    fc_acc_t   word_q;
    fc_acc_t   acc_q;

    // Side band per stage, index 0 after the multiply
    logic      [2:0] vld_q;
    logic      [2:0] last_q;
    fc_class_t cls_q [3];

    // Next valid word starts a new row
    logic      first_q;

    ////////////////////////////////////////////////////////////////////////////
    // Lane split and multiply
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            fm_lane[l] = fc_byte_t'(i_fm_word[l*DATA_W +: DATA_W]);
            wt_lane[l] = fc_byte_t'(i_wt_word[l*DATA_W +: DATA_W]);
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            prod_q[l] <= fm_lane[l] * wt_lane[l];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Two-level adder tree
    ////////////////////////////////////////////////////////////////////////////

    // Four pair sums, then one word sum
    always_comb begin
        word_sum = '0;
        for (int p = 0; p < LANES/2; p++) begin
            word_sum = word_sum + pair_q[p];
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < LANES/2; p++) begin
            pair_q[p] <= prod_q[2*p] + prod_q[2*p+1];
        end
        word_q <= word_sum;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q  <= '0;
            last_q <= '0;
        end else begin
            vld_q  <= {vld_q[1:0], i_valid};
            last_q <= {last_q[1:0], i_valid & i_last};
        end
    end

    always_ff @(posedge clk) begin
        cls_q[0] <= i_class;
        cls_q[1] <= cls_q[0];
        cls_q[2] <= cls_q[1];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Row accumulator
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first_q       <= 1'b1;
            o_score_valid <= 1'b0;
        end else begin
            o_score_valid <= vld_q[2] & last_q[2];
            if (vld_q[2]) begin
                first_q <= last_q[2];
            end
        end
    end

    // Restart from zero on the first word of a row
    always_ff @(posedge clk) begin
        if (vld_q[2]) begin
            acc_q         <= (first_q ? fc_acc_t'('0) : acc_q) + word_q;
            o_score_class <= cls_q[2];
        end
    end

    assign o_score = acc_q;

endmodule

// File: src/fc_addr_gen.sv
// Bases are sampled every cycle and must stay stable while o_busy is high
`timescale 1ns/100ps

module fc_addr_gen (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_start,
    input  fc_types_pkg::fc_fm_base_t i_fm_base,
    input  fc_types_pkg::fc_wt_base_t i_wt_base,
    input  logic                      i_result_taken,
    output fc_types_pkg::fc_fm_addr_t o_fm_addr,
    output fc_types_pkg::fc_wt_addr_t o_wt_addr,
    output logic                      o_rd_valid,
    output logic                      o_last_word,
    output fc_types_pkg::fc_class_t   o_class_idx,
    output logic                      o_busy
);
    import fc_types_pkg::*;
    import fc_geom_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WAIT_RESULT
    } state_t;

    state_t       state;
    fc_word_idx_t word_cnt;
    fc_class_t    class_cnt;
    fc_wt_addr_t  wt_off;
    logic         row_end;
    logic         layer_end;

    assign row_end   = (word_cnt == fc_word_idx_t'(WORDS_PER_ROW - 1));
    assign layer_end = row_end && (class_cnt == fc_class_t'(NUM_CLASSES - 1));

    // Counters sit at zero outside READ, so idle addresses equal the bases
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            word_cnt  <= '0;
            class_cnt <= '0;
            wt_off    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_start) begin
                        state <= READ;
                    end
                end
                READ: begin
                    if (layer_end) begin
                        word_cnt  <= '0;
                        class_cnt <= '0;
                        wt_off    <= '0;
                        state     <= WAIT_RESULT;
                    end else if (row_end) begin
                        word_cnt  <= '0;
                        class_cnt <= class_cnt + 1'b1;
                        // Next weight row
                        wt_off    <= wt_off + fc_wt_addr_t'(WORDS_PER_ROW);
                    end else begin
                        word_cnt  <= word_cnt + 1'b1;
                    end
                end
                WAIT_RESULT: begin
                    if (i_result_taken) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign o_fm_addr = fc_fm_addr_t'(i_fm_base) + fc_fm_addr_t'(word_cnt);
    assign o_wt_addr = fc_wt_addr_t'(i_wt_base) + wt_off + fc_wt_addr_t'(word_cnt);
    assign o_busy    = (state != IDLE);

    // Tags delayed one cycle to meet the memory data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rd_valid  <= 1'b0;
            o_last_word <= 1'b0;
        end else begin
            o_rd_valid  <= (state == READ);
            o_last_word <= (state == READ) && row_end;
        end
    end

    always_ff @(posedge clk) begin
        o_class_idx <= class_cnt;
    end

endmodule

// File: src/fc_argmax.sv
// Class 0 must arrive first in each run; ties keep the lower class index
`timescale 1ns/100ps

module fc_argmax (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_score_valid,
    input  fc_types_pkg::fc_acc_t   i_score,
    input  fc_types_pkg::fc_class_t i_score_class,
    input  logic                    i_result_ready,
    output logic                    o_result_valid,
    output fc_types_pkg::fc_class_t o_class,
    output fc_types_pkg::fc_acc_t   o_score,
    output logic                    o_taken
);
    import fc_types_pkg::*;
    import fc_geom_pkg::*;

    fc_acc_t   best_score;
    fc_class_t best_class;
    fc_acc_t   next_score;
    fc_class_t next_class;
    logic      take;
    logic      last_class;

    // Strict compare, class 0 loads regardless
    assign take       = (i_score_class == '0) || (i_score > best_score);
    assign next_score = take ? i_score : best_score;
    assign next_class = take ? i_score_class : best_class;
    assign last_class = (i_score_class == fc_class_t'(NUM_CLASSES - 1));

    always_ff @(posedge clk) begin
        if (i_score_valid) begin
            best_score <= next_score;
            best_class <= next_class;
        end
        if (i_score_valid && last_class) begin
            o_score <= next_score;
            o_class <= next_class;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result handshake
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_result_valid <= 1'b0;
        end else if (i_score_valid && last_class) begin
            o_result_valid <= 1'b1;
        end else if (o_taken) begin
            o_result_valid <= 1'b0;
        end
    end

    // Transfer cycle, frees the sequencer
    assign o_taken = o_result_valid & i_result_ready;

endmodule

// File: src/fc_layer.sv
// Memories need one cycle of read latency; result valid comes 1397 edges after start is taken
`timescale 1ns/100ps

module fc_layer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_start,
    input  fc_types_pkg::fc_fm_base_t i_fm_base,
    input  fc_types_pkg::fc_wt_base_t i_wt_base,
    input  fc_types_pkg::fc_word_t    i_fm_data,
    input  fc_types_pkg::fc_word_t    i_wt_data,
    output fc_types_pkg::fc_fm_addr_t o_fm_addr,
    output fc_types_pkg::fc_wt_addr_t o_wt_addr,
    output logic                      o_result_valid,
    input  logic                      i_result_ready,
    output fc_types_pkg::fc_class_t   o_class,
    output fc_types_pkg::fc_acc_t     o_score,
    output logic                      o_busy
);
    import fc_types_pkg::*;

    // Sequencer tags, aligned with memory data
    logic      rd_valid;
    logic      last_word;
    fc_class_t class_idx;

    // Per-class scores
    logic      score_valid;
    fc_acc_t   score;
    fc_class_t score_class;

    logic      result_taken;

    fc_addr_gen u_addr_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_start        (i_start),
        .i_fm_base      (i_fm_base),
        .i_wt_base      (i_wt_base),
        .i_result_taken (result_taken),
        .o_fm_addr      (o_fm_addr),
        .o_wt_addr      (o_wt_addr),
        .o_rd_valid     (rd_valid),
        .o_last_word    (last_word),
        .o_class_idx    (class_idx),
        .o_busy         (o_busy)
    );

    fc_front u_front (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_valid       (rd_valid),
        .i_last        (last_word),
        .i_class       (class_idx),
        .i_fm_word     (i_fm_data),
        .i_wt_word     (i_wt_data),
        .o_score_valid (score_valid),
        .o_score       (score),
        .o_score_class (score_class)
    );

    fc_argmax u_argmax (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_score_valid  (score_valid),
        .i_score        (score),
        .i_score_class  (score_class),
        .i_result_ready (i_result_ready),
        .o_result_valid (o_result_valid),
        .o_class        (o_class),
        .o_score        (o_score),
        .o_taken        (result_taken)
    );

endmodule
